// File: include/counter_cfg.svh
`ifndef COUNTER_CFG_SVH
`define COUNTER_CFG_SVH

////////////////////////////////////////
// Counter board sizing
////////////////////////////////////////

// One 161/191 stage
`define STAGE_W 4

// Divider is two cascaded stages
`define DIV_W   8

// Event counter width (590 style)
`define EVT_W   8

// Sequencer outputs, 2 to 16 supported
`define SEQ_LEN 10

`endif

// File: design/counter_pkg.sv
`include "counter_cfg.svh"

package counter_pkg;

   ////////////////////////////////////////
   // Stage operation
   ////////////////////////////////////////

   // What a counter stage does on the next edge
   typedef enum logic [1:0] {
      OP_HOLD = 2'd0,   // Keep count
      OP_LOAD = 2'd1,   // Take preset
      OP_UP   = 2'd2,   // Count + 1
      OP_DOWN = 2'd3    // Count - 1
   } count_op_t;

   ////////////////////////////////////////
   // Control and status bundles
   ////////////////////////////////////////

   typedef struct packed {
      logic              load;     // Reload preset, level
      logic              run;      // Count enable, level
      logic [`DIV_W-1:0] preset;   // Divider start value
   } div_ctrl_t;

   typedef struct packed {
      logic                load;     // Load strobe
      logic                enable;   // Count enable, level
      logic                down;     // High counts down
      logic [`STAGE_W-1:0] preset;
   } updn_ctrl_t;

   typedef struct packed {
      logic [`STAGE_W-1:0] q;    // Current count
      logic                tc;   // Terminal count
      logic                rc;   // Ripple-carry pulse
   } updn_stat_t;

   typedef struct packed {
      logic clear;   // Zero the count
      logic snap;    // Copy count to output register
      logic oe;      // Output enable
   } evt_ctrl_t;

endpackage

// File: design/counter_161.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// 74x161 style presettable 4-bit counter, fully synchronous
module counter_161
   import counter_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  logic                cet,   // Enable, also gates tc
   input  logic                cep,   // Enable, count only
   input  logic                pe,    // Parallel load when high
   input  logic [`STAGE_W-1:0] p,     // Preset value
   output logic [`STAGE_W-1:0] q,     // Count
   output logic                tc     // All ones and cet
);

   count_op_t op;

   ////////////////////////////////////////
   // Input decode
   ////////////////////////////////////////

   always_comb begin
      if (pe) begin
         op = OP_LOAD;             // Load wins over count
      end else if (cet && cep) begin
         op = OP_UP;               // Both enables needed
      end else begin
         op = OP_HOLD;
      end
   end

   ////////////////////////////////////////
   // Count register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else begin
         case (op)
            OP_LOAD: q <= p;
            OP_UP:   q <= q + 1'b1;   // Wraps at 15
            default: q <= q;          // Hold
         endcase
      end
   end

   // Cascade output
   // Next stage uses tc as its cet, no glue needed
   assign tc = cet & (&q);

endmodule

// File: design/counter_191.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// 74x191 style up/down counter
// Steps once per divider tick while enabled
module counter_191
   import counter_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  updn_ctrl_t ctrl,   // Load, enable, direction, preset
   input  logic       tick,   // Count edge qualifier from divider
   output updn_stat_t stat    // Count, tc, rc
);

   count_op_t           op;
   logic [`STAGE_W-1:0] count;
   logic                tc;

   ////////////////////////////////////////
   // Operation decode
   ////////////////////////////////////////

   always_comb begin
      op = OP_HOLD;
      if (ctrl.load) begin
         op = OP_LOAD;                          // Load has priority
      end else if (ctrl.enable && tick) begin
         op = ctrl.down ? OP_DOWN : OP_UP;      // Direction picks step
      end
   end

   ////////////////////////////////////////
   // Count register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case (op)
            OP_LOAD: count <= ctrl.preset;
            OP_UP:   count <= count + 1'b1;   // 15 -> 0
            OP_DOWN: count <= count - 1'b1;   // 0 -> 15
            default: count <= count;
         endcase
      end
   end

   ////////////////////////////////////////
   // Status outputs
   ////////////////////////////////////////

   // Terminal count follows direction
   // 15 going up, 0 going down
   always_comb begin
      if (ctrl.down) begin
         tc = (count == '0);
      end else begin
         tc = (&count);
      end
   end

   assign stat.q  = count;
   assign stat.tc = tc;
   assign stat.rc = tc & ctrl.enable & tick;   // One cycle wide

endmodule

// File: design/counter_590.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// 74x590 style event counter
// Count register plus snapshot output register
module counter_590
   import counter_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  evt_ctrl_t         ctrl,   // Clear, snap, oe
   input  logic              tick,   // One event per tick
   output logic [`EVT_W-1:0] q,      // Snapshot, gated by oe
   output logic              rco     // Count is all ones
);

   logic [`EVT_W-1:0] count;   // Running event count
   logic [`EVT_W-1:0] oreg;    // Stable copy for readout

   ////////////////////////////////////////
   // Event count
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (ctrl.clear) begin
         count <= '0;              // Clear beats the tick
      end else if (tick) begin
         count <= count + 1'b1;    // Wraps past 255
      end
   end

   ////////////////////////////////////////
   // Snapshot register
   ////////////////////////////////////////

   // Takes the count as it stood before this edge
   // Counting carries on undisturbed
   always_ff @(posedge clk) begin
      if (reset) begin
         oreg <= '0;
      end else if (ctrl.snap) begin
         oreg <= count;
      end
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   // Disabled output reads as zero
   assign q = ctrl.oe ? oreg : '0;

   // High at terminal count
   assign rco = &count;

endmodule

// File: design/counter_4017.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// 4017 style sequencer
// One-hot outputs walk forward one step per tick
module counter_4017 (
   input  logic                clk,
   input  logic                reset,
   input  logic                tick,   // Advance enable
   output logic [`SEQ_LEN-1:0] q,      // One-hot position
   output logic                co      // High for first half
);

   localparam int POS_W = $clog2(`SEQ_LEN);

   logic [POS_W-1:0] pos;   // Current position, 0 .. SEQ_LEN-1

   ////////////////////////////////////////
   // Position counter
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         pos <= '0;                            // Output 0 selected
      end else if (tick) begin
         if (pos == POS_W'(`SEQ_LEN - 1)) begin
            pos <= '0;                         // Wrap to start
         end else begin
            pos <= pos + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < `SEQ_LEN; i++) begin
         q[i] = (pos == POS_W'(i));   // Exactly one match
      end
   end

   // 0..4 high for the decade case
   assign co = (pos < POS_W'(`SEQ_LEN / 2));

endmodule

// File: design/counter_board.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// Clock divider and event counting board
// Divider tick drives all downstream counters
module counter_board
   import counter_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  div_ctrl_t           div_ctrl,    // Divider load, run, preset
   input  updn_ctrl_t          updn_ctrl,   // Up/down counter control
   input  evt_ctrl_t           evt_ctrl,    // Event counter control
   output logic [`DIV_W-1:0]   div_q,       // Divider count
   output logic                tick,        // Divider terminal count
   output updn_stat_t          updn_stat,
   output logic [`EVT_W-1:0]   evt_q,
   output logic                evt_rco,
   output logic [`SEQ_LEN-1:0] seq_q,
   output logic                seq_co
);

   logic [`STAGE_W-1:0] lo_q;     // Low divider nibble
   logic [`STAGE_W-1:0] hi_q;     // High divider nibble
   logic                lo_tc;    // Low stage at 15, feeds hi cet
   logic                hi_tc;    // Both stages at 15
   logic                reload;   // Load preset on next edge

   ////////////////////////////////////////
   // Programmable divider
   ////////////////////////////////////////

   // Wrap by reload, so period is 2^DIV_W - preset
   assign reload = tick | div_ctrl.load;

   counter_161 u_div_lo (
      .clk   (clk),
      .reset (reset),
      .cet   (div_ctrl.run),
      .cep   (div_ctrl.run),
      .pe    (reload),
      .p     (div_ctrl.preset[`STAGE_W-1:0]),
      .q     (lo_q),
      .tc    (lo_tc)
   );

   counter_161 u_div_hi (
      .clk   (clk),
      .reset (reset),
      .cet   (lo_tc),          // Ripple enable from low stage
      .cep   (div_ctrl.run),
      .pe    (reload),
      .p     (div_ctrl.preset[`DIV_W-1:`STAGE_W]),
      .q     (hi_q),
      .tc    (hi_tc)
   );

   assign div_q = {hi_q, lo_q};

   // All ones while running
   assign tick = hi_tc & div_ctrl.run;

   ////////////////////////////////////////
   // Tick consumers
   ////////////////////////////////////////

   counter_191 u_updn (
      .clk   (clk),
      .reset (reset),
      .ctrl  (updn_ctrl),
      .tick  (tick),
      .stat  (updn_stat)
   );

   counter_590 u_evt (
      .clk   (clk),
      .reset (reset),
      .ctrl  (evt_ctrl),
      .tick  (tick),
      .q     (evt_q),
      .rco   (evt_rco)
   );

   // Decade sequencer
   counter_4017 u_seq (
      .clk   (clk),
      .reset (reset),
      .tick  (tick),
      .q     (seq_q),
      .co    (seq_co)
   );

endmodule

// File: testbench/counter_board_asserts.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// Properties watched inside every counter_board
module counter_board_asserts
   import counter_pkg::*;
(
   input logic                clk,
   input logic                reset,
   input div_ctrl_t           div_ctrl,    // Run level matters here
   input logic [`DIV_W-1:0]   div_q,
   input logic                tick,
   input updn_ctrl_t          updn_ctrl,   // Direction for terminal count
   input updn_stat_t          updn_stat,
   input logic [`SEQ_LEN-1:0] seq_q
);

   ////////////////////////////////////////
   // Divider and downstream counters
   ////////////////////////////////////////

   // Tick only while running, and only at all ones
   tick_needs_run: assert property (@(posedge clk) disable iff (reset)
      tick |-> div_ctrl.run && (&div_q))
      else $error("Divider tick without run or away from all ones");

   // Exactly one sequencer output at a time
   seq_one_hot: assert property (@(posedge clk) disable iff (reset)
      $onehot(seq_q))
      else $error("Sequencer outputs not one-hot: %b", seq_q);

   rc_needs_tc: assert property (@(posedge clk) disable iff (reset)
      updn_stat.rc |-> tick
                       && (updn_ctrl.down ? (updn_stat.q == '0) : (&updn_stat.q)))
      else $error("Up/down ripple carry without tick at terminal count");

endmodule

bind counter_board counter_board_asserts u_asserts (
   .clk       (clk),
   .reset     (reset),
   .div_ctrl  (div_ctrl),
   .div_q     (div_q),
   .tick      (tick),
   .updn_ctrl (updn_ctrl),
   .updn_stat (updn_stat),
   .seq_q     (seq_q)
);

// File: testbench/counter_board_tb.sv
`timescale 1ns/1ps

`include "counter_cfg.svh"

// Directed tests for the counter board
module counter_board_tb
   import counter_pkg::*;
();

   localparam int RESET_CYCLES = 16;
   localparam int MAX_PERIOD   = 1 << `DIV_W;   // Slowest divider setting
   localparam int NUM_PRESETS  = 3;
   // Three resets, two divider periods per preset, event wrap, margin
   localparam int TIMEOUT_CYCLES = 3 * (RESET_CYCLES + 4)
                                 + NUM_PRESETS * (2 * MAX_PERIOD + 12)
                                 + 2 * MAX_PERIOD + 200;

   typedef logic [`DIV_W-1:0] div_word_t;

   logic                clk = 1'b0;
   logic                reset;
   div_ctrl_t           div_ctrl;
   updn_ctrl_t          updn_ctrl;
   evt_ctrl_t           evt_ctrl;
   logic [`DIV_W-1:0]   div_q;
   logic                tick;
   updn_stat_t          updn_stat;
   logic [`EVT_W-1:0]   evt_q;
   logic                evt_rco;
   logic [`SEQ_LEN-1:0] seq_q;
   logic                seq_co;

   int errors = 0;
   int checks = 0;
   int cycles = 0;

   // Expected state, stepped on each edge from inputs applied before it
   logic [`STAGE_W-1:0] updn_exp;
   logic                updn_step_q;
   logic                updn_down_q;
   logic [`EVT_W-1:0]   evt_cnt;
   logic [`EVT_W-1:0]   evt_snap;
   logic                evt_tick_q;
   logic                evt_clear_q;
   logic                evt_snap_q;
   int                  seq_pos;
   logic                seq_tick_q;

   counter_board UUT (
      .clk       (clk),
      .reset     (reset),
      .div_ctrl  (div_ctrl),
      .updn_ctrl (updn_ctrl),
      .evt_ctrl  (evt_ctrl),
      .div_q     (div_q),
      .tick      (tick),
      .updn_stat (updn_stat),
      .evt_q     (evt_q),
      .evt_rco   (evt_rco),
      .seq_q     (seq_q),
      .seq_co    (seq_co)
   );

   always #50 clk = ~clk;   // 100 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, tests did not complete", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] t=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset     <= 1'b1;
      div_ctrl  <= '0;
      updn_ctrl <= '0;
      evt_ctrl  <= '{clear: 1'b0, snap: 1'b0, oe: 1'b1};
      updn_step_q = 1'b0;
      evt_cnt     = '0;
      evt_snap    = '0;
      evt_tick_q  = 1'b0;
      evt_clear_q = 1'b0;
      evt_snap_q  = 1'b0;
      seq_pos     = 0;
      seq_tick_q  = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
   endtask

   // Load strobe with run low, count lands on preset
   task automatic load_divider(input div_word_t p);
      @(posedge clk);
      div_ctrl <= '{load: 1'b1, run: 1'b0, preset: p};
      @(posedge clk);
      div_ctrl.load <= 1'b0;
      @(negedge clk);
      check_value("div_q after load", 32'(div_q), 32'(p));
      check_value("tick after load", 32'(tick), 32'd0);
   endtask

   task automatic load_updn(input logic [`STAGE_W-1:0] p, input logic down);
      @(posedge clk);
      updn_ctrl <= '{load: 1'b1, enable: 1'b0, down: down, preset: p};
      @(posedge clk);
      updn_ctrl.load <= 1'b0;
      updn_exp    = p;
      updn_step_q = 1'b0;
      updn_down_q = down;
      @(negedge clk);
      check_value("updn q after load", 32'(updn_stat.q), 32'(p));
      check_value("updn rc after load", 32'(updn_stat.rc), 32'd0);
   endtask

   // With preset all ones, tick simply follows run
   task automatic updn_cycle(input logic do_run, input logic en, input logic down);
      logic tc_exp;
      @(posedge clk);
      if (updn_step_q) begin
         updn_exp = updn_down_q ? updn_exp - 1'b1 : updn_exp + 1'b1;   // Wraps
      end
      div_ctrl.run     <= do_run;
      updn_ctrl.enable <= en;
      updn_ctrl.down   <= down;
      updn_step_q = do_run & en;
      updn_down_q = down;
      @(negedge clk);
      tc_exp = down ? (updn_exp == '0) : (updn_exp == '1);
      check_value("updn_stat.q", 32'(updn_stat.q), 32'(updn_exp));
      check_value("updn_stat.tc", 32'(updn_stat.tc), 32'(tc_exp));
      check_value("updn_stat.rc", 32'(updn_stat.rc), 32'(tc_exp & en & do_run));
   endtask

   task automatic evt_cycle(input logic do_run, input logic do_clear, input logic do_snap,
                            input logic oe_level);
      @(posedge clk);
      if (evt_snap_q) begin
         evt_snap = evt_cnt;   // Pre-edge count
      end
      if (evt_clear_q) begin
         evt_cnt = '0;
      end else if (evt_tick_q) begin
         evt_cnt = evt_cnt + 1'b1;
      end
      div_ctrl.run <= do_run;
      evt_ctrl     <= '{clear: do_clear, snap: do_snap, oe: oe_level};
      evt_tick_q  = do_run;
      evt_clear_q = do_clear;
      evt_snap_q  = do_snap;
      @(negedge clk);
      check_value("tick", 32'(tick), 32'(do_run));
      check_value("evt_q", 32'(evt_q), 32'(oe_level ? evt_snap : '0));
      check_value("evt_rco", 32'(evt_rco), 32'(evt_cnt == '1));
   endtask

   task automatic seq_cycle(input logic do_run);
      @(posedge clk);
      if (seq_tick_q) begin
         seq_pos = (seq_pos + 1) % `SEQ_LEN;
      end
      div_ctrl.run <= do_run;
      seq_tick_q = do_run;
      @(negedge clk);
      check_value("seq_q", 32'(seq_q), 32'd1 << seq_pos);
      check_value("seq_co", 32'(seq_co), 32'(seq_pos < `SEQ_LEN / 2));
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic test_reset();
      check_value("div_q", 32'(div_q), 32'd0);
      check_value("tick", 32'(tick), 32'd0);
      check_value("updn_stat.q", 32'(updn_stat.q), 32'd0);
      check_value("updn_stat.rc", 32'(updn_stat.rc), 32'd0);
      check_value("evt_q", 32'(evt_q), 32'd0);
      check_value("evt_rco", 32'(evt_rco), 32'd0);
      check_value("seq_q", 32'(seq_q), 32'd1);
      check_value("seq_co", 32'(seq_co), 32'd1);
   endtask

   task automatic test_divider_period();
      div_word_t p;
      div_word_t exp_q;
      int        period;
      int        last_tick;
      int        ticks_seen;
      for (int k = 0; k < NUM_PRESETS; k++) begin
         p          = div_word_t'($urandom);
         period     = MAX_PERIOD - int'(p);
         last_tick  = -1;
         ticks_seen = 0;
         load_divider(p);
         exp_q = p;
         @(posedge clk);
         div_ctrl.run <= 1'b1;
         for (int n = 0; n < 2 * period; n++) begin
            @(negedge clk);
            check_value("div_q", 32'(div_q), 32'(exp_q));
            check_value("tick", 32'(tick), 32'(exp_q == '1));
            if (tick) begin
               if (last_tick >= 0) begin
                  check_value("tick period", n - last_tick, period);
               end
               last_tick = n;
               ticks_seen++;
            end
            @(posedge clk);
            exp_q = (exp_q == '1) ? p : exp_q + 1'b1;   // Reload at all ones
         end
         div_ctrl.run <= 1'b0;
         repeat (4) begin   // Count must hold
            @(negedge clk);
            check_value("div_q held", 32'(div_q), 32'(exp_q));
            check_value("tick held", 32'(tick), 32'd0);
            @(posedge clk);
         end
         check_value("ticks per two periods", ticks_seen, 2);
      end
   endtask

   task automatic test_updown();
      load_divider('1);
      load_updn(4'd13, 1'b0);
      repeat (5) updn_cycle(1'b1, 1'b1, 1'b0);   // Up through 15
      load_updn(4'd15, 1'b0);
      repeat (3) updn_cycle(1'b1, 1'b0, 1'b0);   // tc without rc
      repeat (5) updn_cycle(1'b1, 1'b1, 1'b1);
      load_updn(4'd2, 1'b1);
      repeat (2) updn_cycle(1'b1, 1'b1, 1'b1);
      updn_cycle(1'b0, 1'b1, 1'b1);              // At 0 with no tick, rc stays low
      repeat (2) updn_cycle(1'b1, 1'b1, 1'b1);   // Down through 0
      updn_cycle(1'b0, 1'b1, 1'b1);
   endtask

   task automatic test_event_counter();
      apply_reset();
      load_divider('1);
      repeat (7) evt_cycle(1'b1, 1'b0, 1'b0, 1'b1);
      evt_cycle(1'b1, 1'b0, 1'b1, 1'b1);   // Snap while counting
      evt_cycle(1'b0, 1'b0, 1'b0, 1'b1);
      check_value("evt_q snapshot", 32'(evt_q), 32'd7);
      evt_cycle(1'b0, 1'b0, 1'b0, 1'b0);   // Output off reads zero
      repeat (250) evt_cycle(1'b1, 1'b0, 1'b0, 1'b1);   // Past 255 and wrap
      evt_cycle(1'b0, 1'b0, 1'b1, 1'b1);
      evt_cycle(1'b0, 1'b1, 1'b0, 1'b1);
      evt_cycle(1'b0, 1'b0, 1'b1, 1'b1);   // Snap the cleared count
      evt_cycle(1'b0, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic test_sequencer();
      apply_reset();
      load_divider('1);
      for (int n = 0; n < 2 * `SEQ_LEN + 3; n++) begin
         seq_cycle(1'b1);
      end
      seq_cycle(1'b0);
   endtask

   initial begin
      void'($urandom(58554));
      reset     <= 1'b1;
      div_ctrl  <= '0;
      updn_ctrl <= '0;
      evt_ctrl  <= '{clear: 1'b0, snap: 1'b0, oe: 1'b1};
      apply_reset();
      test_reset();
      test_divider_period();
      test_updown();
      test_event_counter();
      test_sequencer();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: counter_board.f
+incdir+include
design/counter_pkg.sv
design/counter_161.sv
design/counter_191.sv
design/counter_590.sv
design/counter_4017.sv
design/counter_board.sv
testbench/counter_board_asserts.sv
testbench/counter_board_tb.sv

// File: build.sh
#!/usr/bin/env bash
# Build and run the counter board testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module counter_board_tb \
   -f counter_board.f \
   -o counter_board_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/counter_board_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
